// File: filelist.f
pim_geom_pkg.sv
pim_cmd_pkg.sv
pim_weight_array.sv
pim_bitplane_mac.sv
pim_shift_accum.sv
pim_sequencer.sv
pim_top.sv
pim_checker.sv
tb_pim_top.sv

// File: pim_bitplane_mac.sv
`timescale 1ns/1ps

module pim_bitplane_mac #(
	parameter int ADC_BITS = 6
) (
	input logic clk,
	input logic arst_n,
	input logic plane_valid,
	input logic plane_first,
	input logic plane_last,
	input pim_geom_pkg::plane_t plane,
	input pim_geom_pkg::pidx_t plane_idx,
	input pim_geom_pkg::plane_t [pim_geom_pkg::WGT_W-1:0] wgt_planes,
	output logic col_valid,
	output logic col_first,
	output logic col_last,
	output pim_geom_pkg::pidx_t col_idx,
	output logic [pim_geom_pkg::WGT_W-1:0][ADC_BITS-1:0] col_counts
);

	// Full scale of the column converter
	localparam int ADC_MAX = (1 << ADC_BITS) - 1;

	logic [pim_geom_pkg::WGT_W-1:0][pim_geom_pkg::CNT_W-1:0] raw_cnt;
	logic [pim_geom_pkg::WGT_W-1:0][ADC_BITS-1:0] clip_cnt;

	function automatic logic [pim_geom_pkg::CNT_W-1:0] ones(input pim_geom_pkg::plane_t bits);
		logic [pim_geom_pkg::CNT_W-1:0] n;
		n = '0;
		for (int i = 0; i < pim_geom_pkg::N_IN; i++)
		begin
			n = n + pim_geom_pkg::CNT_W'(bits[i]);
		end
		return n;
	endfunction

	// One column per weight bit, AND then count
	always_comb
	begin
		for (int j = 0; j < pim_geom_pkg::WGT_W; j++)
		begin
			raw_cnt[j] = ones(plane & wgt_planes[j]);
			if (int'(raw_cnt[j]) > ADC_MAX)
			begin
				clip_cnt[j] = ADC_BITS'(ADC_MAX);
			end
			else
			begin
				clip_cnt[j] = ADC_BITS'(raw_cnt[j]);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			col_valid <= 1'b0;
			col_first <= 1'b0;
			col_last <= 1'b0;
			col_idx <= '0;
		end
		else
		begin
			col_valid <= plane_valid;
			col_first <= plane_valid && plane_first;
			col_last <= plane_valid && plane_last;
			col_idx <= plane_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (plane_valid)
		begin
			col_counts <= clip_cnt;
		end
	end

endmodule

// File: pim_checker.sv
`timescale 1ns/1ps

module pim_checker (
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input pim_cmd_pkg::pim_req_t req,
	input logic busy,
	input logic done
);

	// done is registered on edge ACT_W+2, so it is sampled one edge later
	localparam int DONE_LAT = pim_geom_pkg::ACT_W + 3;

	logic accept;

	assign accept = req_valid && !busy && (req.op == pim_cmd_pkg::op_compute);

	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done)
	else $error("done stayed high for more than one cycle");

	done_with_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
		done |-> (!busy && $past(busy)))
	else $error("done did not coincide with busy falling");

	busy_fall_has_done: assert property (@(posedge clk) disable iff (!arst_n)
		$fell(busy) |-> done)
	else $error("busy fell without done");

	done_after_compute: assert property (@(posedge clk) disable iff (!arst_n)
		accept |-> ##DONE_LAT done)
	else $error("done missing at the fixed latency after an accepted compute");

	// No done without a compute accepted at the fixed distance
	done_not_early: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(done) |-> $past(accept, DONE_LAT))
	else $error("done arrived without a matching accepted compute");

endmodule

bind pim_top pim_checker u_checker (
	.clk(clk),
	.arst_n(arst_n),
	.req_valid(req_valid),
	.req(req),
	.busy(busy),
	.done(done)
);

// File: pim_cmd_pkg.sv
package pim_cmd_pkg;

	localparam int ROW_FIELD_W = 8;

	typedef enum logic
	{
		op_write = 1'b0,
		op_compute = 1'b1
	} pim_op_e;

	// Same 256 bits, read as a weight row or as an activation vector
	typedef union packed
	{
		pim_geom_pkg::wgt_row_t wgt;
		pim_geom_pkg::act_vec_t act;
	} pim_payload_u;

	// Only the low bits of row address the array
	typedef struct packed
	{
		pim_op_e op;
		logic [ROW_FIELD_W-1:0] row;
		pim_payload_u payload;
	} pim_req_t;

endpackage

// File: pim_geom_pkg.sv
package pim_geom_pkg;

	// Vector length and element widths
	localparam int N_IN = 32;
	localparam int ACT_W = 8;
	localparam int WGT_W = 8;

	// Holds 32 x 255 x 255
	localparam int RES_W = 21;

	localparam int PIDX_W = $clog2(ACT_W);

	// Column count width before the converter clips it
	localparam int CNT_W = $clog2(N_IN + 1);

	// One bit per element
	typedef logic [N_IN-1:0] plane_t;

	typedef logic [N_IN-1:0][WGT_W-1:0] wgt_row_t;

	typedef logic [N_IN-1:0][ACT_W-1:0] act_vec_t;

	typedef logic [RES_W-1:0] result_t;

	// Activation bit-plane index
	typedef logic [PIDX_W-1:0] pidx_t;

endpackage

// File: pim_sequencer.sv
`timescale 1ns/1ps

module pim_sequencer #(
	parameter int ROWS = 16,
	localparam int ROW_W = $clog2(ROWS)
) (
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input pim_cmd_pkg::pim_req_t req,
	output logic wr_en,
	output logic [ROW_W-1:0] wr_row,
	output pim_geom_pkg::wgt_row_t wr_data,
	output logic [ROW_W-1:0] rd_row,
	output logic plane_valid,
	output logic plane_first,
	output logic plane_last,
	output pim_geom_pkg::plane_t plane,
	output pim_geom_pkg::pidx_t plane_idx,
	output logic busy
);

	// Planes go out on steps 0 to ACT_W-1, the pipeline drains by LAST_STEP
	localparam int LAST_STEP = pim_geom_pkg::ACT_W + 1;
	localparam int STEP_W = $clog2(LAST_STEP + 1);

	logic [STEP_W-1:0] step;
	pim_geom_pkg::act_vec_t act_q;
	logic take_write;
	logic take_compute;

	// Anything strobed while busy is dropped
	assign take_write = req_valid && !busy && (req.op == pim_cmd_pkg::op_write);
	assign take_compute = req_valid && !busy && (req.op == pim_cmd_pkg::op_compute);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_en <= 1'b0;
			rd_row <= '0;
			busy <= 1'b0;
			step <= '0;
		end
		else
		begin
			wr_en <= take_write;
			if (take_compute)
			begin
				busy <= 1'b1;
				step <= '0;
				rd_row <= req.row[ROW_W-1:0];
			end
			else if (busy)
			begin
				if (step == STEP_W'(LAST_STEP))
				begin
					busy <= 1'b0;
				end
				else
				begin
					step <= step + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_write)
		begin
			wr_row <= req.row[ROW_W-1:0];
			wr_data <= req.payload.wgt;
		end
		if (take_compute)
		begin
			act_q <= req.payload.act;
		end
	end

	assign plane_valid = busy && (step < STEP_W'(pim_geom_pkg::ACT_W));
	assign plane_first = plane_valid && (step == '0);
	assign plane_last = plane_valid && (step == STEP_W'(pim_geom_pkg::ACT_W - 1));
	assign plane_idx = step[pim_geom_pkg::PIDX_W-1:0];

	// Bit k of every latched activation
	always_comb
	begin
		for (int n = 0; n < pim_geom_pkg::N_IN; n++)
		begin
			plane[n] = act_q[n][plane_idx];
		end
	end

endmodule

// File: pim_shift_accum.sv
`timescale 1ns/1ps

module pim_shift_accum #(
	parameter int ADC_BITS = 6
) (
	input logic clk,
	input logic arst_n,
	input logic col_valid,
	input logic col_first,
	input logic col_last,
	input pim_geom_pkg::pidx_t col_idx,
	input logic [pim_geom_pkg::WGT_W-1:0][ADC_BITS-1:0] col_counts,
	output logic done,
	output pim_geom_pkg::result_t result
);

	// Enough for a clipped count times 2^WGT_W - 1
	localparam int TERM_W = ADC_BITS + pim_geom_pkg::WGT_W;

	logic [TERM_W-1:0] col_sum;
	pim_geom_pkg::result_t plane_term;
	pim_geom_pkg::result_t acc;
	logic fin_q;

	// Counts weighted by their weight bit
	always_comb
	begin
		col_sum = '0;
		for (int j = 0; j < pim_geom_pkg::WGT_W; j++)
		begin
			col_sum = col_sum + (TERM_W'(col_counts[j]) << j);
		end
	end

	// Then by the activation bit
	assign plane_term = pim_geom_pkg::result_t'(col_sum) << col_idx;

	always_ff @(posedge clk)
	begin
		if (col_valid)
		begin
			acc <= (col_first ? '0 : acc) + plane_term;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			fin_q <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			fin_q <= col_valid && col_last;
			done <= fin_q;
			if (fin_q)
			begin
				result <= acc;
			end
		end
	end

endmodule

// File: pim_top.sv
`timescale 1ns/1ps

module pim_top #(
	parameter int ROWS = 16,
	parameter int ADC_BITS = 6,
	localparam int ROW_W = $clog2(ROWS)
) (
	input logic clk,
	input logic arst_n,
	input logic req_valid,
	input pim_cmd_pkg::pim_req_t req,
	output logic busy,
	output logic done,
	output pim_geom_pkg::result_t result
);

	logic wr_en;
	logic [ROW_W-1:0] wr_row;
	pim_geom_pkg::wgt_row_t wr_data;
	logic [ROW_W-1:0] rd_row;
	logic plane_valid;
	logic plane_first;
	logic plane_last;
	pim_geom_pkg::plane_t plane;
	pim_geom_pkg::pidx_t plane_idx;
	pim_geom_pkg::plane_t [pim_geom_pkg::WGT_W-1:0] wgt_planes;
	logic col_valid;
	logic col_first;
	logic col_last;
	pim_geom_pkg::pidx_t col_idx;
	logic [pim_geom_pkg::WGT_W-1:0][ADC_BITS-1:0] col_counts;

	pim_sequencer #(.ROWS(ROWS)) u_seq (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req(req),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.rd_row(rd_row),
		.plane_valid(plane_valid),
		.plane_first(plane_first),
		.plane_last(plane_last),
		.plane(plane),
		.plane_idx(plane_idx),
		.busy(busy)
	);

	pim_weight_array #(.ROWS(ROWS)) u_array (
		.clk(clk),
		.arst_n(arst_n),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.rd_row(rd_row),
		.wgt_planes(wgt_planes)
	);

	pim_bitplane_mac #(.ADC_BITS(ADC_BITS)) u_mac (
		.clk(clk),
		.arst_n(arst_n),
		.plane_valid(plane_valid),
		.plane_first(plane_first),
		.plane_last(plane_last),
		.plane(plane),
		.plane_idx(plane_idx),
		.wgt_planes(wgt_planes),
		.col_valid(col_valid),
		.col_first(col_first),
		.col_last(col_last),
		.col_idx(col_idx),
		.col_counts(col_counts)
	);

	pim_shift_accum #(.ADC_BITS(ADC_BITS)) u_accum (
		.clk(clk),
		.arst_n(arst_n),
		.col_valid(col_valid),
		.col_first(col_first),
		.col_last(col_last),
		.col_idx(col_idx),
		.col_counts(col_counts),
		.done(done),
		.result(result)
	);

endmodule

// File: pim_weight_array.sv
`timescale 1ns/1ps

module pim_weight_array #(
	parameter int ROWS = 16,
	localparam int ROW_W = $clog2(ROWS)
) (
	input logic clk,
	input logic arst_n,
	input logic wr_en,
	input logic [ROW_W-1:0] wr_row,
	input pim_geom_pkg::wgt_row_t wr_data,
	input logic [ROW_W-1:0] rd_row,
	output pim_geom_pkg::plane_t [pim_geom_pkg::WGT_W-1:0] wgt_planes
);

	pim_geom_pkg::wgt_row_t mem [ROWS];
	pim_geom_pkg::wgt_row_t rd_data;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int r = 0; r < ROWS; r++)
			begin
				mem[r] <= '0;
			end
		end
		else if (wr_en)
		begin
			mem[wr_row] <= wr_data;
		end
	end

	assign rd_data = mem[rd_row];

	// Transpose the addressed row, weight bit j of every element forms plane j
	always_comb
	begin
		for (int j = 0; j < pim_geom_pkg::WGT_W; j++)
		begin
			for (int n = 0; n < pim_geom_pkg::N_IN; n++)
			begin
				wgt_planes[j][n] = rd_data[n][j];
			end
		end
	end

endmodule

// File: run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

for adc in 6 4
do
	obj="obj_adc${adc}"
	log="sim_adc${adc}.log"
	verilator --binary --timing --assert -Wno-fatal -GADC_BITS=${adc} \
		--top-module tb_pim_top -Mdir "${obj}" -f filelist.f
	"./${obj}/Vtb_pim_top" > "${log}" 2>&1 || true
	cat "${log}"
	if ! grep -q "^=== PASS ===$" "${log}"
	then
		echo "Simulation with ADC_BITS=${adc} did not pass"
		exit 1
	fi
done

echo "All builds passed"

// File: tb_pim_top.sv
`timescale 1ns/1ps

module tb_pim_top #(
	parameter int ADC_BITS = 6
);

	localparam int ROWS = 16;
	localparam int TIMEOUT_CYC = 40;

	logic clk;
	logic arst_n;
	logic req_valid;
	pim_cmd_pkg::pim_req_t req;
	logic busy;
	logic done;
	pim_geom_pkg::result_t result;

	// Model copy of the weight store
	pim_geom_pkg::wgt_row_t model_mem [ROWS];

	pim_top #(.ROWS(ROWS), .ADC_BITS(ADC_BITS)) u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req(req),
		.busy(busy),
		.done(done),
		.result(result)
	);

	always #50 clk = ~clk;

	task automatic stop_on_failure();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after a failed check");
	endtask

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			$display("[FAIL] %0d ns %s: got %0d, expected %0d", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	function automatic pim_geom_pkg::wgt_row_t random_bytes();
		pim_geom_pkg::wgt_row_t v;
		for (int n = 0; n < pim_geom_pkg::N_IN; n++)
		begin
			v[n] = 8'($urandom);
		end
		return v;
	endfunction

	// Bit-sliced rule with the converter clip
	function automatic pim_geom_pkg::result_t expected_result(input pim_geom_pkg::wgt_row_t w,
		input pim_geom_pkg::act_vec_t a);
		longint sum;
		int cnt;
		int lim;
		lim = (1 << ADC_BITS) - 1;
		sum = 0;
		for (int i = 0; i < pim_geom_pkg::ACT_W; i++)
		begin
			for (int j = 0; j < pim_geom_pkg::WGT_W; j++)
			begin
				cnt = 0;
				for (int n = 0; n < pim_geom_pkg::N_IN; n++)
				begin
					if (a[n][i] && w[n][j])
					begin
						cnt++;
					end
				end
				if (cnt > lim)
				begin
					cnt = lim;
				end
				sum += longint'(cnt) << (i + j);
			end
		end
		return pim_geom_pkg::result_t'(sum);
	endfunction

	function automatic longint exact_dot(input pim_geom_pkg::wgt_row_t w,
		input pim_geom_pkg::act_vec_t a);
		longint sum;
		sum = 0;
		for (int n = 0; n < pim_geom_pkg::N_IN; n++)
		begin
			sum += longint'(w[n]) * longint'(a[n]);
		end
		return sum;
	endfunction

	task automatic strobe_write(input int row, input pim_geom_pkg::wgt_row_t data);
		req_valid = 1'b1;
		req.op = pim_cmd_pkg::op_write;
		req.row = 8'(row);
		req.payload.wgt = data;
		next_cycle();
		req_valid = 1'b0;
	endtask

	task automatic strobe_compute(input int row, input pim_geom_pkg::act_vec_t act);
		req_valid = 1'b1;
		req.op = pim_cmd_pkg::op_compute;
		req.row = 8'(row);
		req.payload.act = act;
		next_cycle();
		req_valid = 1'b0;
	endtask

	task automatic write_row(input int row, input pim_geom_pkg::wgt_row_t data);
		strobe_write(row, data);
		model_mem[row] = data;
	endtask

	// Counts edges from the accepting edge
	task automatic wait_done(input int start_cycles, output pim_geom_pkg::result_t res);
		int cycles;
		cycles = start_cycles;
		while (!done)
		begin
			next_cycle();
			cycles++;
			if (cycles > TIMEOUT_CYC)
			begin
				$display("Timeout: done did not arrive within %0d cycles", TIMEOUT_CYC);
				stop_on_failure();
			end
		end
		check_eq(64'(cycles), 64'(pim_geom_pkg::ACT_W + 2), "done latency");
		check_eq(64'(busy), 64'(0), "busy low at done");
		res = result;
	endtask

	task automatic compute_and_check(input int row, input pim_geom_pkg::act_vec_t act,
		input string what);
		pim_geom_pkg::result_t res;
		strobe_compute(row, act);
		check_eq(64'(busy), 64'(1), "busy after accepted compute");
		wait_done(0, res);
		check_eq(64'(res), 64'(expected_result(model_mem[row], act)), what);
	endtask

	task automatic reset_state_is_idle();
		check_eq(64'(busy), 64'(0), "busy after reset");
		check_eq(64'(done), 64'(0), "done after reset");
		check_eq(64'(result), 64'(0), "result after reset");
		compute_and_check(5, random_bytes(), "unwritten row");
	endtask

	task automatic known_row_sums_weights();
		pim_geom_pkg::wgt_row_t w;
		pim_geom_pkg::act_vec_t ones;
		longint sum;
		sum = 0;
		// Only 15 nonzero weights, so no column clips in either build
		for (int n = 0; n < pim_geom_pkg::N_IN; n++)
		begin
			w[n] = (n < 15) ? 8'(n * 17 + 5) : 8'd0;
			ones[n] = 8'd1;
			sum += longint'(w[n]);
		end
		write_row(1, w);
		compute_and_check(1, ones, "known row");
		check_eq(64'(result), 64'(sum), "sum of weights");
	endtask

	task automatic random_rows_match_model();
		pim_geom_pkg::wgt_row_t full;
		int row;
		full = '1;
		for (int r = 2; r < 10; r++)
		begin
			write_row(r, random_bytes());
		end
		write_row(10, full);
		for (int t = 0; t < 12; t++)
		begin
			row = 2 + int'($urandom % 8);
			compute_and_check(row, random_bytes(), "random compute");
		end
		compute_and_check(10, full, "all 255");
	endtask

	task automatic busy_requests_ignored();
		pim_geom_pkg::act_vec_t act;
		pim_geom_pkg::result_t res;
		act = random_bytes();
		write_row(11, random_bytes());
		write_row(3, random_bytes());
		strobe_compute(3, act);
		strobe_write(11, random_bytes());
		strobe_compute(11, random_bytes());
		wait_done(2, res);
		check_eq(64'(res), 64'(expected_result(model_mem[3], act)), "result while strobed");
		next_cycle();
		check_eq(64'(busy), 64'(0), "second compute ignored");
		compute_and_check(11, random_bytes(), "old weights kept");
	endtask

	task automatic back_to_back_computes();
		for (int t = 0; t < 4; t++)
		begin
			compute_and_check(2 + t, random_bytes(), "back to back");
		end
	endtask

	task automatic converter_clipping();
		pim_geom_pkg::wgt_row_t w;
		pim_geom_pkg::act_vec_t a;
		w = random_bytes();
		a = random_bytes();
		// Upper bits set everywhere, so those columns count 32
		for (int n = 0; n < pim_geom_pkg::N_IN; n++)
		begin
			w[n] = w[n] | 8'hf0;
			a[n] = a[n] | 8'hf0;
		end
		write_row(12, w);
		compute_and_check(12, a, "dense vector");
		if (ADC_BITS == 4)
		begin
			check_eq(64'(longint'(result) < exact_dot(w, a)), 64'(1), "clipping active");
		end
		compute_and_check(12, '1, "dense all ones");
	endtask

	initial
	begin
		void'($urandom(32'hc579));
		clk = 1'b0;
		arst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		for (int r = 0; r < ROWS; r++)
		begin
			model_mem[r] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;
		next_cycle();
		reset_state_is_idle();
		known_row_sums_weights();
		random_rows_match_model();
		busy_requests_ignored();
		back_to_back_computes();
		converter_clipping();
		$display("=== PASS ===");
		$finish;
	end

endmodule
